// File: include/bridge_settings.svh
// Widths, channel counts and reader depth of the memory bridge
// The reader's order queue assumes BRIDGE_LOAD_DEPTH of 2 or more
// Channel counts must be 1 or more
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Data word carried on stores and load payloads
`define BRIDGE_DATA_W 64

// Big memory and small memory address widths
`define BRIDGE_WIDE_ADDR_W 2
`define BRIDGE_NARROW_ADDR_W 4

// Kernel-side channel counts
`define BRIDGE_N_STORE 4
`define BRIDGE_N_LOAD 3

// Load requests that may be outstanding in one reader
`define BRIDGE_LOAD_DEPTH 4

`endif

// File: design/bridge_types_pkg.sv
// Kernel-side types of the memory bridge
// Store packets keep the address in the upper bits, as on the write stream
`default_nettype none

`include "bridge_settings.svh"

package bridge_types_pkg;

  // One data word
  typedef logic [`BRIDGE_DATA_W-1:0] data_t;

  // Big memory and small memory addresses
  typedef logic [`BRIDGE_WIDE_ADDR_W-1:0] wide_addr_t;
  typedef logic [`BRIDGE_NARROW_ADDR_W-1:0] narrow_addr_t;

  // Store request from the kernel
  typedef struct packed {
    wide_addr_t address;
    data_t      data;
  } store_pkt_t;

  // Per-channel handshake vectors
  typedef logic [`BRIDGE_N_STORE-1:0] store_mask_t;
  typedef logic [`BRIDGE_N_LOAD-1:0] load_mask_t;

endpackage

`default_nettype wire

// File: design/axis_types_pkg.sv
// Memory-side stream beats, one beat per transfer and no tlast
// store_beat_t has the same field layout as the kernel store packet
`default_nettype none

`include "bridge_settings.svh"

package axis_types_pkg;

  // Write stream beat, address on top
  typedef struct packed {
    logic [`BRIDGE_WIDE_ADDR_W-1:0] address;
    logic [`BRIDGE_DATA_W-1:0]      data;
  } store_beat_t;

  // Request streams carry the address only
  typedef logic [`BRIDGE_WIDE_ADDR_W-1:0] wide_req_t;
  typedef logic [`BRIDGE_NARROW_ADDR_W-1:0] narrow_req_t;

  // Payload stream carries the data only
  typedef logic [`BRIDGE_DATA_W-1:0] pl_beat_t;

endpackage

`default_nettype wire

// File: design/channel_arbiter.sv
// Round-robin merge of N_CH valid/ready channels onto one output beat
// Output is registered, so a grant in cycle n is visible from cycle n+1
// Callers mask req_valid for channels that must not be granted
`default_nettype none

module channel_arbiter #(
  parameter int N_CH = 2,
  parameter type payload_t = logic [7:0]
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [N_CH-1:0]      req_valid,
  input  payload_t             req_payload [N_CH],
  output logic [N_CH-1:0]      req_ready,
  output logic                 out_valid,
  output payload_t             out_payload,
  input  logic                 out_ready,
  output logic [((N_CH > 1) ? $clog2(N_CH) : 1)-1:0] out_channel
);

  localparam int CH_W = (N_CH > 1) ? $clog2(N_CH) : 1;

  logic [CH_W-1:0] last_grant;
  logic [CH_W-1:0] grant_idx;
  logic            grant_found;
  logic            load_ok;
  logic            take;

  // Output register free now or draining this cycle
  assign load_ok = !out_valid || out_ready;
  assign take    = grant_found && load_ok;

  // Search starts at the channel after the last grant
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int k = 1; k <= N_CH; k++) begin
      idx = (int'(last_grant) + k) % N_CH;
      if (!grant_found && req_valid[idx]) begin
        grant_found = 1'b1;
        grant_idx   = CH_W'(idx);
      end
    end
  end

  always_comb begin
    req_ready = '0;
    if (take) begin
      req_ready[grant_idx] = 1'b1;
    end
  end

  // Pointer resets to the top channel so channel 0 wins first
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      last_grant <= CH_W'(N_CH - 1);
    end else if (take) begin
      out_valid  <= 1'b1;
      last_grant <= grant_idx;
    end else if (out_ready) begin
      out_valid  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_payload <= req_payload[grant_idx];
      out_channel <= grant_idx;
    end
  end

  // --------------------------------------------------
  a_ready_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(req_ready));

  a_hold_beat: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_payload));

endmodule

`default_nettype wire

// File: design/store_stream_writer.sv
// Store channels merged onto one write stream
// Each channel has at most one store in flight until its done is taken
`default_nettype none

`include "bridge_settings.svh"

module store_stream_writer
  import bridge_types_pkg::*;
  import axis_types_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  store_pkt_t  st_pkt [`BRIDGE_N_STORE],
  input  store_mask_t st_valid,
  output store_mask_t st_ready,
  output store_beat_t wr_tdata,
  output logic        wr_tvalid,
  input  logic        wr_tready,
  output store_mask_t st_done_valid,
  input  store_mask_t st_done_ready
);

  localparam int N_ST = `BRIDGE_N_STORE;
  localparam int CH_W = (N_ST > 1) ? $clog2(N_ST) : 1;

  store_mask_t     done_pending;
  store_mask_t     in_flight;
  store_mask_t     arb_valid_in;
  store_pkt_t      arb_payload;
  logic [CH_W-1:0] arb_channel;
  logic            beat_fire;

  // Channel whose beat sits in the output register
  always_comb begin
    in_flight = '0;
    if (wr_tvalid) begin
      in_flight[arb_channel] = 1'b1;
    end
  end

  assign arb_valid_in = st_valid & ~done_pending & ~in_flight;

  channel_arbiter #(
    .N_CH      (N_ST),
    .payload_t (store_pkt_t)
  ) u_arb (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (arb_valid_in),
    .req_payload (st_pkt),
    .req_ready   (st_ready),
    .out_valid   (wr_tvalid),
    .out_payload (arb_payload),
    .out_ready   (wr_tready),
    .out_channel (arb_channel)
  );

  assign wr_tdata  = store_beat_t'(arb_payload);
  assign beat_fire = wr_tvalid && wr_tready;

  // Done rises the cycle after the write beat leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      done_pending <= '0;
    end else begin
      for (int i = 0; i < N_ST; i++) begin
        if (beat_fire && arb_channel == CH_W'(i)) begin
          done_pending[i] <= 1'b1;
        end else if (st_done_ready[i]) begin
          done_pending[i] <= 1'b0;
        end
      end
    end
  end

  assign st_done_valid = done_pending;

  a_no_double_done: assert property (@(posedge clk) disable iff (reset)
    beat_fire |-> !done_pending[arb_channel]);

endmodule

`default_nettype wire

// File: design/load_stream_reader.sv
// Load channels merged onto one request stream, payloads routed back
// Memory must return payloads in request order, one per request
// At most BRIDGE_LOAD_DEPTH requests are outstanding, the beat waiting
// in the output register included
`default_nettype none

`include "bridge_settings.svh"

module load_stream_reader
  import bridge_types_pkg::*;
#(
  parameter int N_CH   = 3,
  parameter int ADDR_W = 2
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] ld_addr [N_CH],
  input  logic [N_CH-1:0]   ld_addr_valid,
  output logic [N_CH-1:0]   ld_addr_ready,
  output data_t             ld_data [N_CH],
  output logic [N_CH-1:0]   ld_data_valid,
  input  logic [N_CH-1:0]   ld_data_ready,
  output logic [ADDR_W-1:0] req_tdata,
  output logic              req_tvalid,
  input  logic              req_tready,
  input  data_t             pl_tdata,
  input  logic              pl_tvalid,
  output logic              pl_tready
);

  localparam int CH_W  = (N_CH > 1) ? $clog2(N_CH) : 1;
  localparam int DEPTH = `BRIDGE_LOAD_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Order queue of channel numbers
  logic [CH_W-1:0]  q_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W:0]   outstanding;
  logic [CH_W-1:0]  head;
  logic [CH_W-1:0]  arb_channel;
  logic             q_nonempty;
  logic             full;
  logic             push;
  logic             pop;

  assign outstanding = {1'b0, count} + {{CNT_W{1'b0}}, req_tvalid};
  assign full        = outstanding >= (CNT_W + 1)'(DEPTH);

  channel_arbiter #(
    .N_CH      (N_CH),
    .payload_t (logic [ADDR_W-1:0])
  ) u_arb (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (full ? '0 : ld_addr_valid),
    .req_payload (ld_addr),
    .req_ready   (ld_addr_ready),
    .out_valid   (req_tvalid),
    .out_payload (req_tdata),
    .out_ready   (req_tready),
    .out_channel (arb_channel)
  );

  assign push = req_tvalid && req_tready;

  // --------------------------------------------------
  // Payload steering, combinational from the head entry
  assign q_nonempty = count != '0;
  assign head       = q_mem[rd_ptr];
  assign pl_tready  = q_nonempty && ld_data_ready[head];
  assign pop        = pl_tvalid && pl_tready;

  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      ld_data[i]       = pl_tdata;
      ld_data_valid[i] = pl_tvalid && q_nonempty && head == CH_W'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= arb_channel;
    end
  end

  // Order queue never holds more than its depth
  a_queue_bound: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH));

  // Memory answers only requests already sent or leaving now
  a_no_stray_payload: assert property (@(posedge clk) disable iff (reset)
    pl_tvalid |-> q_nonempty || push);

endmodule

`default_nettype wire

// File: design/kernel_mem_bridge.sv
// Kernel load/store channels to single-beat memory streams
// One store writer and two load readers (big memory, small memory)
// Every transfer is one beat; valid/ready only
`default_nettype none

`include "bridge_settings.svh"

module kernel_mem_bridge
  import bridge_types_pkg::*;
  import axis_types_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  // Store channels
  input  store_pkt_t   st_pkt [`BRIDGE_N_STORE],
  input  store_mask_t  st_valid,
  output store_mask_t  st_ready,
  output store_mask_t  st_done_valid,
  input  store_mask_t  st_done_ready,
  // Write stream
  output store_beat_t  wr_tdata,
  output logic         wr_tvalid,
  input  logic         wr_tready,
  // Wide load channels
  input  wide_addr_t   wide_ld_addr [`BRIDGE_N_LOAD],
  input  load_mask_t   wide_ld_addr_valid,
  output load_mask_t   wide_ld_addr_ready,
  output data_t        wide_ld_data [`BRIDGE_N_LOAD],
  output load_mask_t   wide_ld_data_valid,
  input  load_mask_t   wide_ld_data_ready,
  // Wide memory streams
  output wide_req_t    wide_req_tdata,
  output logic         wide_req_tvalid,
  input  logic         wide_req_tready,
  input  pl_beat_t     wide_pl_tdata,
  input  logic         wide_pl_tvalid,
  output logic         wide_pl_tready,
  // Narrow load channel
  input  narrow_addr_t narrow_ld_addr,
  input  logic         narrow_ld_addr_valid,
  output logic         narrow_ld_addr_ready,
  output data_t        narrow_ld_data,
  output logic         narrow_ld_data_valid,
  input  logic         narrow_ld_data_ready,
  // Narrow memory streams
  output narrow_req_t  narrow_req_tdata,
  output logic         narrow_req_tvalid,
  input  logic         narrow_req_tready,
  input  pl_beat_t     narrow_pl_tdata,
  input  logic         narrow_pl_tvalid,
  output logic         narrow_pl_tready
);

  // One-entry arrays for the single narrow channel
  narrow_addr_t narrow_addr_arr [1];
  data_t        narrow_data_arr [1];

  assign narrow_addr_arr[0] = narrow_ld_addr;
  assign narrow_ld_data     = narrow_data_arr[0];

  store_stream_writer u_writer (
    .clk           (clk),
    .reset         (reset),
    .st_pkt        (st_pkt),
    .st_valid      (st_valid),
    .st_ready      (st_ready),
    .wr_tdata      (wr_tdata),
    .wr_tvalid     (wr_tvalid),
    .wr_tready     (wr_tready),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready)
  );

  // --------------------------------------------------
  load_stream_reader #(
    .N_CH   (`BRIDGE_N_LOAD),
    .ADDR_W (`BRIDGE_WIDE_ADDR_W)
  ) u_wide_reader (
    .clk           (clk),
    .reset         (reset),
    .ld_addr       (wide_ld_addr),
    .ld_addr_valid (wide_ld_addr_valid),
    .ld_addr_ready (wide_ld_addr_ready),
    .ld_data       (wide_ld_data),
    .ld_data_valid (wide_ld_data_valid),
    .ld_data_ready (wide_ld_data_ready),
    .req_tdata     (wide_req_tdata),
    .req_tvalid    (wide_req_tvalid),
    .req_tready    (wide_req_tready),
    .pl_tdata      (wide_pl_tdata),
    .pl_tvalid     (wide_pl_tvalid),
    .pl_tready     (wide_pl_tready)
  );

  load_stream_reader #(
    .N_CH   (1),
    .ADDR_W (`BRIDGE_NARROW_ADDR_W)
  ) u_narrow_reader (
    .clk           (clk),
    .reset         (reset),
    .ld_addr       (narrow_addr_arr),
    .ld_addr_valid (narrow_ld_addr_valid),
    .ld_addr_ready (narrow_ld_addr_ready),
    .ld_data       (narrow_data_arr),
    .ld_data_valid (narrow_ld_data_valid),
    .ld_data_ready (narrow_ld_data_ready),
    .req_tdata     (narrow_req_tdata),
    .req_tvalid    (narrow_req_tvalid),
    .req_tready    (narrow_req_tready),
    .pl_tdata      (narrow_pl_tdata),
    .pl_tvalid     (narrow_pl_tvalid),
    .pl_tready     (narrow_pl_tready)
  );

endmodule

`default_nettype wire

// File: verif/tb_kernel_mem_bridge.sv
// Testbench for kernel_mem_bridge, run from the project root (reads verif/bridge_cases.txt)
// Store fork branches assume 4 store channels, load fork branches assume 3 wide channels
// Memory model answers requests in order; narrow memory is never written
`default_nettype none

`include "bridge_settings.svh"

module tb_kernel_mem_bridge
  import bridge_types_pkg::*;
  import axis_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ST            = `BRIDGE_N_STORE;
  localparam int N_LD            = `BRIDGE_N_LOAD;
  localparam int DEPTH           = `BRIDGE_LOAD_DEPTH;
  localparam int NARROW_IDX      = N_LD;
  localparam int WIDE_WORDS      = 1 << `BRIDGE_WIDE_ADDR_W;
  localparam int NARROW_WORDS    = 1 << `BRIDGE_NARROW_ADDR_W;
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_CASE = 200;

  localparam int K_STORE  = 0;
  localparam int K_BURST  = 1;
  localparam int K_LOAD   = 2;
  localparam int K_MULTI  = 3;
  localparam int K_NARROW = 4;
  localparam int K_BAD    = 5;

  logic         clk;
  logic         reset;
  store_pkt_t   st_pkt [N_ST];
  store_mask_t  st_valid;
  store_mask_t  st_ready;
  store_mask_t  st_done_valid;
  store_mask_t  st_done_ready;
  store_beat_t  wr_tdata;
  logic         wr_tvalid;
  logic         wr_tready;
  wide_addr_t   wide_ld_addr [N_LD];
  load_mask_t   wide_ld_addr_valid;
  load_mask_t   wide_ld_addr_ready;
  data_t        wide_ld_data [N_LD];
  load_mask_t   wide_ld_data_valid;
  load_mask_t   wide_ld_data_ready;
  wide_req_t    wide_req_tdata;
  logic         wide_req_tvalid;
  logic         wide_req_tready;
  pl_beat_t     wide_pl_tdata;
  logic         wide_pl_tvalid;
  logic         wide_pl_tready;
  narrow_addr_t narrow_ld_addr;
  logic         narrow_ld_addr_valid;
  logic         narrow_ld_addr_ready;
  data_t        narrow_ld_data;
  logic         narrow_ld_data_valid;
  logic         narrow_ld_data_ready;
  narrow_req_t  narrow_req_tdata;
  logic         narrow_req_tvalid;
  logic         narrow_req_tready;
  pl_beat_t     narrow_pl_tdata;
  logic         narrow_pl_tvalid;
  logic         narrow_pl_tready;

  // Memory model state
  data_t       wide_mem [WIDE_WORDS];
  data_t       narrow_mem [NARROW_WORDS];
  data_t       wide_pl_q [$];
  data_t       narrow_pl_q [$];
  logic        wide_pl_taken;
  logic        narrow_pl_taken;
  int          wide_reqs;
  int          wide_pls;
  int          narrow_reqs;
  int          narrow_pls;

  // Observed traffic
  store_beat_t wr_log [$];
  time         wr_time [$];
  logic        wr_wait;
  store_beat_t wr_held;
  int          st_accept_cnt [N_ST];
  int          done_cnt [N_ST];
  time         done_time [N_ST];
  int          ld_accept_cnt [N_LD+1];
  int          ld_data_cnt [N_LD+1];
  data_t       ld_got [N_LD+1];
  int          ld_issued [N_LD+1];
  int          stores_issued;
  int          last_store_ch;

  // Cases and results
  int          case_kind [$];
  int          case_ch [$];
  logic [63:0] case_addr [$];
  logic [63:0] case_data [$];
  logic [63:0] case_exp [$];
  int          n_cases;
  logic        cases_loaded;
  int          mismatches;
  int          failures;

  kernel_mem_bridge uut (
    .clk                  (clk),
    .reset                (reset),
    .st_pkt               (st_pkt),
    .st_valid             (st_valid),
    .st_ready             (st_ready),
    .st_done_valid        (st_done_valid),
    .st_done_ready        (st_done_ready),
    .wr_tdata             (wr_tdata),
    .wr_tvalid            (wr_tvalid),
    .wr_tready            (wr_tready),
    .wide_ld_addr         (wide_ld_addr),
    .wide_ld_addr_valid   (wide_ld_addr_valid),
    .wide_ld_addr_ready   (wide_ld_addr_ready),
    .wide_ld_data         (wide_ld_data),
    .wide_ld_data_valid   (wide_ld_data_valid),
    .wide_ld_data_ready   (wide_ld_data_ready),
    .wide_req_tdata       (wide_req_tdata),
    .wide_req_tvalid      (wide_req_tvalid),
    .wide_req_tready      (wide_req_tready),
    .wide_pl_tdata        (wide_pl_tdata),
    .wide_pl_tvalid       (wide_pl_tvalid),
    .wide_pl_tready       (wide_pl_tready),
    .narrow_ld_addr       (narrow_ld_addr),
    .narrow_ld_addr_valid (narrow_ld_addr_valid),
    .narrow_ld_addr_ready (narrow_ld_addr_ready),
    .narrow_ld_data       (narrow_ld_data),
    .narrow_ld_data_valid (narrow_ld_data_valid),
    .narrow_ld_data_ready (narrow_ld_data_ready),
    .narrow_req_tdata     (narrow_req_tdata),
    .narrow_req_tvalid    (narrow_req_tvalid),
    .narrow_req_tready    (narrow_req_tready),
    .narrow_pl_tdata      (narrow_pl_tdata),
    .narrow_pl_tvalid     (narrow_pl_tvalid),
    .narrow_pl_tready     (narrow_pl_tready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input logic [65:0] got, input logic [65:0] exp,
                             input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int decode_kind(input logic [63:0] word);
    case (word)
      "store":  return K_STORE;
      "burst":  return K_BURST;
      "load":   return K_LOAD;
      "multi":  return K_MULTI;
      "narrow": return K_NARROW;
      default:  return K_BAD;
    endcase
  endfunction

  // --------------------------------------------------
  // Memory model and traffic monitor, sampled on the rising edge
  always @(posedge clk) begin
    if (!reset) begin
      if (wr_wait) begin
        if (!wr_tvalid) begin
          failures++;
          $display("Error at %0t ns: write beat withdrawn before it was accepted", $time);
        end else begin
          check_value(wr_tdata, wr_held, "write beat held under back-pressure");
        end
      end
      wr_wait = wr_tvalid && !wr_tready;
      wr_held = wr_tdata;
      if (wr_tvalid && wr_tready) begin
        wr_log.push_back(wr_tdata);
        wr_time.push_back($time);
        wide_mem[wr_tdata.address] = wr_tdata.data;
      end
      for (int i = 0; i < N_ST; i++) begin
        if (st_valid[i] && st_ready[i]) begin
          st_accept_cnt[i]++;
        end
        if (st_done_valid[i] && st_done_ready[i]) begin
          done_cnt[i]++;
          done_time[i] = $time;
        end
      end
      // Payload pops before the request push of the same edge
      if (wide_pl_tvalid && wide_pl_tready) begin
        void'(wide_pl_q.pop_front());
        wide_pl_taken = 1'b1;
        wide_pls++;
      end
      if (wide_req_tvalid && wide_req_tready) begin
        wide_pl_q.push_back(wide_mem[wide_req_tdata]);
        wide_reqs++;
      end
      if (narrow_pl_tvalid && narrow_pl_tready) begin
        void'(narrow_pl_q.pop_front());
        narrow_pl_taken = 1'b1;
        narrow_pls++;
      end
      if (narrow_req_tvalid && narrow_req_tready) begin
        narrow_pl_q.push_back(narrow_mem[narrow_req_tdata]);
        narrow_reqs++;
      end
      if (wide_reqs - wide_pls > DEPTH || narrow_reqs - narrow_pls > DEPTH) begin
        failures++;
        $display("Error at %0t ns: more than %0d load requests outstanding", $time, DEPTH);
      end
      for (int i = 0; i < N_LD; i++) begin
        if (wide_ld_addr_valid[i] && wide_ld_addr_ready[i]) begin
          ld_accept_cnt[i]++;
        end
        if (wide_ld_data_valid[i] && wide_ld_data_ready[i]) begin
          ld_got[i] = wide_ld_data[i];
          ld_data_cnt[i]++;
        end
      end
      if (narrow_ld_addr_valid && narrow_ld_addr_ready) begin
        ld_accept_cnt[NARROW_IDX]++;
      end
      if (narrow_ld_data_valid && narrow_ld_data_ready) begin
        ld_got[NARROW_IDX] = narrow_ld_data;
        ld_data_cnt[NARROW_IDX]++;
      end
    end
  end

  // Random stalls on the memory side; a raised payload holds until taken
  always @(negedge clk) begin
    wr_tready         = ($urandom % 4) != 0;
    wide_req_tready   = ($urandom % 4) != 0;
    narrow_req_tready = ($urandom % 4) != 0;
    if (!wide_pl_tvalid || wide_pl_taken) begin
      wide_pl_taken  = 1'b0;
      wide_pl_tvalid = (wide_pl_q.size() > 0) && (($urandom % 3) == 0);
      wide_pl_tdata  = (wide_pl_q.size() > 0) ? wide_pl_q[0] : '0;
    end
    if (!narrow_pl_tvalid || narrow_pl_taken) begin
      narrow_pl_taken  = 1'b0;
      narrow_pl_tvalid = (narrow_pl_q.size() > 0) && (($urandom % 3) == 0);
      narrow_pl_tdata  = (narrow_pl_q.size() > 0) ? narrow_pl_q[0] : '0;
    end
  end

  // --------------------------------------------------
  task automatic init_inputs();
    clk                  = 1'b0;
    reset                = 1'b1;
    st_valid             = '0;
    st_done_ready        = '1;
    wr_tready            = 1'b0;
    wide_ld_addr_valid   = '0;
    wide_ld_data_ready   = '1;
    wide_req_tready      = 1'b0;
    wide_pl_tdata        = '0;
    wide_pl_tvalid       = 1'b0;
    narrow_ld_addr       = '0;
    narrow_ld_addr_valid = 1'b0;
    narrow_ld_data_ready = 1'b1;
    narrow_req_tready    = 1'b0;
    narrow_pl_tdata      = '0;
    narrow_pl_tvalid     = 1'b0;
    wide_pl_taken        = 1'b0;
    narrow_pl_taken      = 1'b0;
    wr_wait              = 1'b0;
    wr_held              = '0;
    last_store_ch        = N_ST - 1;
    cases_loaded         = 1'b0;
    for (int i = 0; i < N_ST; i++) begin
      st_pkt[i] = '0;
    end
    for (int i = 0; i < N_LD; i++) begin
      wide_ld_addr[i] = '0;
    end
    // Fill patterns depend on every address bit
    for (int a = 0; a < WIDE_WORDS; a++) begin
      wide_mem[a] = 64'hDEAD_BEEF_0000_0000 | 64'(a);
    end
    for (int a = 0; a < NARROW_WORDS; a++) begin
      narrow_mem[a] = 64'h1111_1111 * 64'(a + 1);
    end
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    int          ch;
    int          kind;
    int          limit;
    string       line;
    logic [63:0] kind_word;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] exp;
    fd = $fopen("verif/bridge_cases.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("Error: cannot open the case file verif/bridge_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          kind_word = '0;
          n     = $sscanf(line, "%s %d %h %h %h", kind_word, ch, addr, data, exp);
          kind  = decode_kind(kind_word);
          limit = (kind <= K_BURST) ? N_ST : ((kind == K_NARROW) ? 1 : N_LD);
          if (n != 5 || kind == K_BAD || ch < 0 || ch >= limit) begin
            failures++;
            $display("Error: unreadable case line: %s", line);
          end else begin
            case_kind.push_back(kind);
            case_ch.push_back(ch);
            case_addr.push_back(addr);
            case_data.push_back(data);
            case_exp.push_back(exp);
          end
        end
      end
      $fclose(fd);
    end
    n_cases = case_kind.size();
  endtask

  task automatic check_idle(input string when);
    if (wr_tvalid || wide_req_tvalid || narrow_req_tvalid || st_ready != '0 ||
        st_done_valid != '0 || wide_ld_addr_ready != '0 || narrow_ld_addr_ready ||
        wide_ld_data_valid != '0 || narrow_ld_data_valid) begin
      failures++;
      $display("Error at %0t ns: bridge outputs not idle %s", $time, when);
    end
  endtask

  // One store on one channel, through to its done handshake
  task automatic do_store(input int ch, input store_pkt_t pkt);
    int accepted;
    int done_before;
    @(negedge clk);
    accepted     = st_accept_cnt[ch];
    done_before  = done_cnt[ch];
    st_pkt[ch]   = pkt;
    st_valid[ch] = 1'b1;
    stores_issued++;
    while (st_accept_cnt[ch] == accepted) @(negedge clk);
    st_valid[ch] = 1'b0;
    while (done_cnt[ch] == done_before) @(negedge clk);
  endtask

  // One load; index NARROW_IDX selects the narrow port
  task automatic do_load(input int idx, input logic [63:0] addr, input logic [63:0] exp);
    int accepted;
    int received;
    @(negedge clk);
    accepted = ld_accept_cnt[idx];
    received = ld_data_cnt[idx];
    if (idx == NARROW_IDX) begin
      narrow_ld_addr       = narrow_addr_t'(addr);
      narrow_ld_addr_valid = 1'b1;
    end else begin
      wide_ld_addr[idx]       = wide_addr_t'(addr);
      wide_ld_addr_valid[idx] = 1'b1;
    end
    ld_issued[idx]++;
    while (ld_accept_cnt[idx] == accepted) @(negedge clk);
    if (idx == NARROW_IDX) begin
      narrow_ld_addr_valid = 1'b0;
    end else begin
      wide_ld_addr_valid[idx] = 1'b0;
    end
    while (ld_data_cnt[idx] == received) @(negedge clk);
    check_value(ld_got[idx], exp, $sformatf("load data on channel %0d", idx));
  endtask

  // Stores from case lines first..last-1, all started in one cycle
  task automatic run_stores(input int first, input int last);
    store_pkt_t      pkts [N_ST];
    logic [N_ST-1:0] used;
    int              done_before [N_ST];
    int              order [$];
    int              base;
    int              c;
    used = '0;
    for (int k = first; k < last; k++) begin
      c       = case_ch[k];
      used[c] = 1'b1;
      pkts[c] = '{address: wide_addr_t'(case_addr[k]), data: case_data[k]};
    end
    for (int k = 1; k <= N_ST; k++) begin
      c = (last_store_ch + k) % N_ST;
      if (used[c]) begin
        order.push_back(c);
      end
    end
    for (int i = 0; i < N_ST; i++) begin
      done_before[i] = done_cnt[i];
    end
    base = wr_log.size();
    fork
      if (used[0]) do_store(0, pkts[0]);
      if (used[1]) do_store(1, pkts[1]);
      if (used[2]) do_store(2, pkts[2]);
      if (used[3]) do_store(3, pkts[3]);
    join
    if (wr_log.size() != base + order.size()) begin
      failures++;
      $display("Error at %0t ns: %0d write beats seen for %0d stores",
               $time, wr_log.size() - base, order.size());
    end else begin
      for (int k = 0; k < order.size(); k++) begin
        check_value(wr_log[base + k], pkts[order[k]], $sformatf("write beat %0d", k));
        check_value(done_time[order[k]], wr_time[base + k] + CLK_PERIOD,
                    $sformatf("done time of store channel %0d", order[k]));
      end
    end
    for (int i = 0; i < N_ST; i++) begin
      check_value(done_cnt[i], done_before[i] + int'(used[i]),
                  $sformatf("done count of store channel %0d", i));
    end
    last_store_ch = order[order.size() - 1];
  endtask

  task automatic run_loads(input int first, input int last);
    logic [N_LD-1:0] used;
    logic [63:0]     addr [N_LD];
    logic [63:0]     exp [N_LD];
    int              c;
    used = '0;
    for (int k = first; k < last; k++) begin
      c       = case_ch[k];
      used[c] = 1'b1;
      addr[c] = case_addr[k];
      exp[c]  = case_exp[k];
    end
    fork
      if (used[0]) do_load(0, addr[0], exp[0]);
      if (used[1]) do_load(1, addr[1], exp[1]);
      if (used[2]) do_load(2, addr[2], exp[2]);
    join
  endtask

  // --------------------------------------------------
  initial begin
    int i;
    int j;
    void'($urandom(88));
    init_inputs();
    read_cases();
    cases_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_idle("during reset");
    reset = 1'b0;
    @(negedge clk);
    check_idle("after reset");

    i = 0;
    while (i < n_cases) begin
      j = i + 1;
      if (case_kind[i] == K_BURST || case_kind[i] == K_MULTI) begin
        while (j < n_cases && case_kind[j] == case_kind[i]) j++;
      end
      if (case_kind[i] == K_STORE || case_kind[i] == K_BURST) begin
        run_stores(i, j);
      end else if (case_kind[i] == K_LOAD || case_kind[i] == K_MULTI) begin
        run_loads(i, j);
      end else begin
        do_load(NARROW_IDX, case_addr[i], case_exp[i]);
      end
      i = j;
    end

    // Let stray beats or payloads show up
    repeat (10) @(negedge clk);
    check_value(wr_log.size(), stores_issued, "write beats against stores issued");
    for (int k = 0; k <= N_LD; k++) begin
      check_value(ld_data_cnt[k], ld_issued[k], $sformatf("payloads on load channel %0d", k));
    end
    check_value(wide_pl_q.size() + narrow_pl_q.size(), 0, "payloads left in memory model");

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog, scaled by the number of cases
  initial begin
    wait (cases_loaded);
    repeat (RESET_CYCLES + n_cases * CYCLES_PER_CASE + 50) @(posedge clk);
    $display("Timeout at %0t ns: the cases did not finish in time", $time);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: kernel_mem_bridge.f
+incdir+include
design/bridge_types_pkg.sv
design/axis_types_pkg.sv
design/channel_arbiter.sv
design/store_stream_writer.sv
design/load_stream_reader.sv
design/kernel_mem_bridge.sv
verif/tb_kernel_mem_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the kernel_mem_bridge testbench with Verilator.
# Run from anywhere; paths are taken relative to this script's folder.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f kernel_mem_bridge.f \
  --top-module tb_kernel_mem_bridge \
  -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_kernel_mem_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0

// File: verif/bridge_cases.txt
# kind  channel  address(hex)  data(hex)  expected load data(hex)
# Adjacent burst lines run together, as do adjacent multi lines; narrow uses channel 0
burst   0  0  3000000000000000  0
burst   1  1  3000000000000001  0
burst   2  2  3000000000000002  0
burst   3  3  3000000000000003  0
store   0  0  1000000000000001  0
store   2  1  2000000000000002  0
load    0  0  0  1000000000000001
load    1  1  0  2000000000000002
load    2  2  0  3000000000000002
store   1  3  4000000000000004  0
load    0  3  0  4000000000000004
multi   0  2  0  3000000000000002
multi   1  3  0  4000000000000004
multi   2  0  0  1000000000000001
store   3  2  5000000000000005  0
load    1  2  0  5000000000000005
narrow  0  3  0  0000000044444444
narrow  0  f  0  0000000111111110
narrow  0  0  0  0000000011111111
narrow  0  9  0  00000000aaaaaaaa
